// ==== rtl/cache_geom_pkg.sv ====
package cache_geom_pkg;

	// data word as seen by the processor and memory
	typedef logic [31:0] word_t;

	// byte address, split as tag | index | word offset | byte offset
	typedef logic [31:0] addr_t;

	// two words per block
	localparam int WORDS_PER_BLK = 2;

	// word offset width within a block
	localparam int OFF_W = $clog2(WORDS_PER_BLK);

	// byte offset bits below the word offset, never looked at
	localparam int BYTE_OFF_W = 2;

	// word in a block, used for the access and for the block walk
	typedef logic [OFF_W-1:0] woff_t;

	// last word of a block
	localparam woff_t LAST_WORD = woff_t'(WORDS_PER_BLK - 1);

endpackage

// ==== rtl/cache_ctrl_pkg.sv ====
package cache_ctrl_pkg;

	// controller FSM states
	typedef enum logic [2:0] {
		IDLE      = 3'd0,
		WRITEBACK = 3'd1,
		FILL      = 3'd2,
		FLUSH     = 3'd3,
		DONE      = 3'd4
	} ctrl_state_t;

	// decoded processor request
	typedef enum logic [2:0] {
		NONE       = 3'd0,
		READ       = 3'd1,
		WRITE      = 3'd2,
		LOAD_LINK  = 3'd3,
		STORE_COND = 3'd4
	} req_op_t;

endpackage

// ==== rtl/way_if.sv ====
`timescale 1ns/1ps

interface way_if #(
	parameter int SETS = 8
);
	import cache_geom_pkg::*;

	localparam int IDX_W = $clog2(SETS);
	localparam int TAG_W = $bits(addr_t) - IDX_W - OFF_W - BYTE_OFF_W;

	// lookup and update address, from the controller
	logic [IDX_W-1:0] index;
	logic [TAG_W-1:0] tag;
	woff_t            offset;

	// update strobes
	logic  wr_word;
	word_t wdata;
	logic  fill_tag;
	logic  set_valid;
	logic  set_dirty;
	logic  clr_entry;

	// lookup result from the way
	logic             hit;
	logic             valid;
	logic             dirty;
	logic [TAG_W-1:0] stored_tag;
	word_t            rdata;

	modport way (
		input  index, tag, offset, wr_word, wdata, fill_tag, set_valid, set_dirty, clr_entry,
		output hit, valid, dirty, stored_tag, rdata
	);

	modport ctrl (
		output index, tag, offset, wr_word, wdata, fill_tag, set_valid, set_dirty, clr_entry,
		input  hit, valid, dirty, stored_tag, rdata
	);

endinterface

// ==== rtl/cache_way.sv ====
`timescale 1ns/1ps

module cache_way #(
	parameter int SETS = 8
) (
	input logic CLK,
	input logic nRST,
	way_if.way  bus
);
	import cache_geom_pkg::*;

	localparam int IDX_W = $clog2(SETS);
	localparam int TAG_W = $bits(addr_t) - IDX_W - OFF_W - BYTE_OFF_W;

	// per-set state bits
	logic [SETS-1:0] valid_q;
	logic [SETS-1:0] dirty_q;

	// tag and block storage
	logic [TAG_W-1:0] tag_q  [SETS];
	word_t            data_q [SETS][WORDS_PER_BLK];

	// combinational read at the current index
	assign bus.valid      = valid_q[bus.index];
	assign bus.dirty      = dirty_q[bus.index];
	assign bus.stored_tag = tag_q[bus.index];
	assign bus.rdata      = data_q[bus.index][bus.offset];

	// tag compare, only a valid entry can hit
	assign bus.hit = valid_q[bus.index] && (tag_q[bus.index] == bus.tag);

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			// every entry invalid after reset
			valid_q <= '0;
			dirty_q <= '0;
		end else begin
			// clear after flush write-back wins
			if (bus.clr_entry) begin
				valid_q[bus.index] <= 1'b0;
			end else if (bus.set_valid) begin
				valid_q[bus.index] <= 1'b1;
			end
			// a refilled block starts clean
			if (bus.clr_entry) begin
				dirty_q[bus.index] <= 1'b0;
			end else if (bus.fill_tag) begin
				dirty_q[bus.index] <= 1'b0;
			end else if (bus.wr_word && bus.set_dirty) begin
				dirty_q[bus.index] <= 1'b1;
			end
		end
	end

	always_ff @(posedge CLK) begin
		// one word per cycle, hit store or refill
		if (bus.wr_word) begin
			data_q[bus.index][bus.offset] <= bus.wdata;
		end
		// new tag on the last refill word
		if (bus.fill_tag) begin
			tag_q[bus.index] <= bus.tag;
		end
	end

	// word update and flush clear come from different FSM states
	a_no_write_on_clear: assert property (
		@(posedge CLK) disable iff (!nRST) !(bus.wr_word && bus.clr_entry)
	);

endmodule

// ==== rtl/cache_ctrl.sv ====
`timescale 1ns/1ps

module cache_ctrl #(
	parameter int SETS = 8
) (
	input  logic                  CLK,
	input  logic                  nRST,
	input  logic                  halt,
	input  logic                  dmem_ren,
	input  logic                  dmem_wen,
	input  logic                  datomic,
	input  cache_geom_pkg::addr_t dmem_addr,
	input  cache_geom_pkg::word_t dmem_store,
	output logic                  dhit,
	output logic                  flushed,
	output cache_geom_pkg::word_t dmem_load,
	output logic                  mem_ren,
	output logic                  mem_wen,
	output cache_geom_pkg::addr_t mem_addr,
	output cache_geom_pkg::word_t mem_store,
	input  cache_geom_pkg::word_t mem_load,
	input  logic                  mem_wait,
	way_if.ctrl                   way0,
	way_if.ctrl                   way1
);
	import cache_geom_pkg::*;
	import cache_ctrl_pkg::*;

	localparam int IDX_W = $clog2(SETS);
	localparam int TAG_W = $bits(addr_t) - IDX_W - OFF_W - BYTE_OFF_W;

	ctrl_state_t      state_q, next_state;
	req_op_t          op;
	woff_t            cnt_q, next_cnt;
	logic [IDX_W:0]   fl_ent_q, next_fl_ent;
	logic [SETS-1:0]  lru_q;
	logic [TAG_W-1:0] req_tag, miss_tag_q, bus_tag;
	logic [IDX_W-1:0] req_idx, miss_idx_q, bus_idx, fl_set;
	woff_t            req_off, bus_off;
	logic             victim_q, fl_way, sel_way, hit_way, any_hit;
	logic             sel_valid, sel_dirty, sc_ok, store_ok, start_miss, entry_done;
	logic [TAG_W-1:0] sel_tag;
	word_t            sel_rdata, hit_rdata, wdata;
	logic             wr_en, wr_way, wr_dirty, fill_en, clr_en;
	addr_t            link_addr_q;
	logic             link_valid_q;

	// address fields of the processor request
	assign req_tag = dmem_addr[$bits(addr_t)-1 -: TAG_W];
	assign req_idx = dmem_addr[BYTE_OFF_W+OFF_W +: IDX_W];
	assign req_off = dmem_addr[BYTE_OFF_W +: OFF_W];

	// flush entry counter holds the way in bit 0 and the set above it
	// word of the entry comes from cnt_q
	assign fl_set = fl_ent_q[IDX_W:1];
	assign fl_way = fl_ent_q[0];

	// request decode
	// both enables together decode as no request
	always_comb begin
		op = NONE;
		if (dmem_ren && !dmem_wen) begin
			op = datomic ? LOAD_LINK : READ;
		end else if (dmem_wen && !dmem_ren) begin
			op = datomic ? STORE_COND : WRITE;
		end
	end

	// hit combine with way 0 taking priority
	assign any_hit   = way0.hit || way1.hit;
	assign hit_way   = !way0.hit;
	assign hit_rdata = hit_way ? way1.rdata : way0.rdata;
	assign dhit      = (state_q == IDLE) && !halt && (op != NONE) && any_hit;

	// store-conditional only against a live link at the same address
	assign sc_ok    = link_valid_q && (dmem_addr == link_addr_q);
	assign store_ok = dhit && ((op == WRITE) || ((op == STORE_COND) && sc_ok));
	assign dmem_load = (op == STORE_COND) ? word_t'(sc_ok) : hit_rdata;

	assign flushed = (state_q == DONE);

	// way picked for victim check, write-back, fill or flush
	always_comb begin
		case (state_q)
			IDLE:    sel_way = lru_q[req_idx];
			FLUSH:   sel_way = fl_way;
			default: sel_way = victim_q;
		endcase
	end

	assign sel_valid = sel_way ? way1.valid : way0.valid;
	assign sel_dirty = sel_way ? way1.dirty : way0.dirty;
	assign sel_tag   = sel_way ? way1.stored_tag : way0.stored_tag;
	assign sel_rdata = sel_way ? way1.rdata : way0.rdata;

	always_comb begin
		next_state  = state_q;
		next_cnt    = cnt_q;
		next_fl_ent = fl_ent_q;
		mem_ren     = 1'b0;
		mem_wen     = 1'b0;
		mem_addr    = '0;
		mem_store   = '0;
		bus_idx     = req_idx;
		bus_tag     = req_tag;
		bus_off     = req_off;
		wr_en       = 1'b0;
		wr_way      = sel_way;
		wr_dirty    = 1'b0;
		wdata       = dmem_store;
		fill_en     = 1'b0;
		clr_en      = 1'b0;
		start_miss  = 1'b0;
		entry_done  = 1'b0;
		case (state_q)
			IDLE: begin
				next_cnt    = '0;
				next_fl_ent = '0;
				if (halt) begin
					next_state = FLUSH;
				end else if ((op != NONE) && !any_hit) begin
					// on a miss the dirty LRU victim goes out first
					start_miss = 1'b1;
					next_state = (sel_valid && sel_dirty) ? WRITEBACK : FILL;
				end else if (store_ok) begin
					wr_en    = 1'b1;
					wr_way   = hit_way;
					wr_dirty = 1'b1;
				end
			end
			WRITEBACK: begin
				bus_idx   = miss_idx_q;
				bus_tag   = miss_tag_q;
				bus_off   = cnt_q;
				mem_wen   = 1'b1;
				mem_addr  = {sel_tag, miss_idx_q, cnt_q, {BYTE_OFF_W{1'b0}}};
				mem_store = sel_rdata;
				if (!mem_wait) begin
					next_cnt = cnt_q + 1'b1;
					if (cnt_q == LAST_WORD) begin
						next_state = FILL;
					end
				end
			end
			FILL: begin
				bus_idx  = miss_idx_q;
				bus_tag  = miss_tag_q;
				bus_off  = cnt_q;
				mem_ren  = 1'b1;
				mem_addr = {miss_tag_q, miss_idx_q, cnt_q, {BYTE_OFF_W{1'b0}}};
				wdata    = mem_load;
				if (!mem_wait) begin
					wr_en    = 1'b1;
					next_cnt = cnt_q + 1'b1;
					// tag and valid go in with the last word
					if (cnt_q == LAST_WORD) begin
						fill_en    = 1'b1;
						next_state = IDLE;
					end
				end
			end
			FLUSH: begin
				bus_idx = fl_set;
				bus_off = cnt_q;
				if (sel_valid && sel_dirty) begin
					mem_wen   = 1'b1;
					mem_addr  = {sel_tag, fl_set, cnt_q, {BYTE_OFF_W{1'b0}}};
					mem_store = sel_rdata;
					if (!mem_wait) begin
						next_cnt = cnt_q + 1'b1;
						if (cnt_q == LAST_WORD) begin
							clr_en     = 1'b1;
							entry_done = 1'b1;
						end
					end
				end else begin
					// clean or empty entries are skipped
					entry_done = 1'b1;
				end
				if (entry_done) begin
					next_fl_ent = fl_ent_q + 1'b1;
					if (&fl_ent_q) begin
						next_state = DONE;
					end
				end
			end
			DONE: begin
				// held until reset
				next_state = DONE;
			end
			default: next_state = IDLE;
		endcase
	end

	// shared lookup address and data to both ways
	assign way0.index = bus_idx;
	assign way1.index = bus_idx;
	assign way0.tag = bus_tag;
	assign way1.tag = bus_tag;
	assign way0.offset = bus_off;
	assign way1.offset = bus_off;
	assign way0.wdata = wdata;
	assign way1.wdata = wdata;
	assign way0.set_dirty = wr_dirty;
	assign way1.set_dirty = wr_dirty;

	// per-way strobes
	assign way0.wr_word = wr_en && !wr_way;
	assign way1.wr_word = wr_en && wr_way;
	assign way0.fill_tag = fill_en && !wr_way;
	assign way1.fill_tag = fill_en && wr_way;
	assign way0.set_valid = fill_en && !wr_way;
	assign way1.set_valid = fill_en && wr_way;
	assign way0.clr_entry = clr_en && !wr_way;
	assign way1.clr_entry = clr_en && wr_way;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state_q      <= IDLE;
			cnt_q        <= '0;
			fl_ent_q     <= '0;
			lru_q        <= '0;
			link_valid_q <= 1'b0;
		end else begin
			state_q  <= next_state;
			cnt_q    <= next_cnt;
			fl_ent_q <= next_fl_ent;
			// LRU points away from the way last used
			if (dhit) begin
				lru_q[req_idx] <= !hit_way;
			end else if (fill_en) begin
				lru_q[miss_idx_q] <= !victim_q;
			end
			// any store to the linked address breaks the link
			if (dhit && (op == LOAD_LINK)) begin
				link_valid_q <= 1'b1;
			end else if (store_ok && (dmem_addr == link_addr_q)) begin
				link_valid_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge CLK) begin
		// miss context for write-back and refill
		if (start_miss) begin
			miss_tag_q <= req_tag;
			miss_idx_q <= req_idx;
			victim_q   <= lru_q[req_idx];
		end
		if (dhit && (op == LOAD_LINK)) begin
			link_addr_q <= dmem_addr;
		end
	end

	a_mem_one_dir: assert property (
		@(posedge CLK) disable iff (!nRST) !(mem_ren && mem_wen)
	);

	// a block is filled only on a miss so it lives in one way only
	a_single_hit: assert property (
		@(posedge CLK) disable iff (!nRST) (state_q == IDLE) |-> !(way0.hit && way1.hit)
	);

endmodule

// ==== rtl/dcache_top.sv ====
`timescale 1ns/1ps

module dcache_top #(
	parameter int SETS = 8
) (
	input  logic                  CLK,
	input  logic                  nRST,
	// processor side
	input  logic                  halt,
	input  logic                  dmem_ren,
	input  logic                  dmem_wen,
	input  logic                  datomic,
	input  cache_geom_pkg::addr_t dmem_addr,
	input  cache_geom_pkg::word_t dmem_store,
	output logic                  dhit,
	output cache_geom_pkg::word_t dmem_load,
	output logic                  flushed,
	// memory side
	output logic                  mem_ren,
	output logic                  mem_wen,
	output cache_geom_pkg::addr_t mem_addr,
	output cache_geom_pkg::word_t mem_store,
	input  cache_geom_pkg::word_t mem_load,
	input  logic                  mem_wait
);

	// one bus per way
	way_if #(.SETS(SETS)) way0_bus ();
	way_if #(.SETS(SETS)) way1_bus ();

	cache_way #(.SETS(SETS)) way0_i (.CLK(CLK), .nRST(nRST), .bus(way0_bus));
	cache_way #(.SETS(SETS)) way1_i (.CLK(CLK), .nRST(nRST), .bus(way1_bus));

	cache_ctrl #(.SETS(SETS)) ctrl_i (
		.CLK(CLK), .nRST(nRST),
		.halt(halt), .dmem_ren(dmem_ren), .dmem_wen(dmem_wen), .datomic(datomic),
		.dmem_addr(dmem_addr), .dmem_store(dmem_store),
		.dhit(dhit), .flushed(flushed), .dmem_load(dmem_load),
		.mem_ren(mem_ren), .mem_wen(mem_wen), .mem_addr(mem_addr), .mem_store(mem_store),
		.mem_load(mem_load), .mem_wait(mem_wait),
		.way0(way0_bus), .way1(way1_bus)
	);

endmodule

// ==== tb/mem_model.sv ====
`timescale 1ns/1ps

module mem_model #(
	parameter int WORDS = 256
) (
	input  logic                  CLK,
	input  logic                  nRST,
	input  logic                  mem_ren,
	input  logic                  mem_wen,
	input  cache_geom_pkg::addr_t mem_addr,
	input  cache_geom_pkg::word_t mem_store,
	output cache_geom_pkg::word_t mem_load,
	output logic                  mem_wait
);
	import cache_geom_pkg::*;

	localparam int AW = $clog2(WORDS);

	// word-addressed backing store
	word_t         mem [WORDS];
	logic [1:0]    wait_q;
	logic [AW-1:0] widx;
	integer        seed;

	initial begin
		seed = 32'h8c4569b2;
	end

	assign widx     = mem_addr[AW+1:2];
	assign mem_load = mem[widx];
	// wait only while a transfer is pending
	assign mem_wait = (mem_ren || mem_wen) && (wait_q != 2'd0);

	always @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			wait_q <= 2'd0;
			// every word starts at its byte address xor a fixed mask
			for (int i = 0; i < WORDS; i++) begin
				mem[i] <= addr_t'(i * 4) ^ 32'hA5A50000;
			end
		end else if (mem_ren || mem_wen) begin
			if (wait_q != 2'd0) begin
				wait_q <= wait_q - 2'd1;
			end else begin
				// word done, pick 0 to 3 waits for the next one
				if (mem_wen) begin
					mem[widx] <= mem_store;
				end
				wait_q <= 2'($random(seed));
			end
		end
	end

endmodule

// ==== tb/dcache_tb.sv ====
`timescale 1ns/1ps

module dcache_tb;
	import cache_geom_pkg::*;

	localparam int SETS        = 8;
	localparam int MEM_WORDS   = 256;
	localparam int MEM_AW      = $clog2(MEM_WORDS);
	localparam int HALF_PERIOD = 20;
	localparam int RST_CYCLES  = 16;
	localparam int LINE_CYCLES = 200;

	logic  CLK;
	logic  nRST;
	logic  halt, dmem_ren, dmem_wen, datomic;
	addr_t dmem_addr;
	word_t dmem_store;
	logic  dhit, flushed;
	word_t dmem_load;
	logic  mem_ren, mem_wen, mem_wait;
	addr_t mem_addr;
	word_t mem_store, mem_load;

	// requests from the data file
	string ops [$];
	addr_t addrs [$];
	word_t stores [$];
	word_t expects [$];
	int    must_hit [$];

	// memory image as the processor should see it
	word_t exp_mem [MEM_WORDS];

	int   checks;
	int   value_errors;
	int   other_errors;
	logic loaded;
	logic traffic;

	dcache_top #(.SETS(SETS)) dut_i (
		.CLK(CLK), .nRST(nRST),
		.halt(halt), .dmem_ren(dmem_ren), .dmem_wen(dmem_wen), .datomic(datomic),
		.dmem_addr(dmem_addr), .dmem_store(dmem_store),
		.dhit(dhit), .dmem_load(dmem_load), .flushed(flushed),
		.mem_ren(mem_ren), .mem_wen(mem_wen), .mem_addr(mem_addr), .mem_store(mem_store),
		.mem_load(mem_load), .mem_wait(mem_wait)
	);

	mem_model #(.WORDS(MEM_WORDS)) mem_i (
		.CLK(CLK), .nRST(nRST),
		.mem_ren(mem_ren), .mem_wen(mem_wen), .mem_addr(mem_addr),
		.mem_store(mem_store), .mem_load(mem_load), .mem_wait(mem_wait)
	);

	initial begin
		CLK = 1'b0;
		forever begin
			#HALF_PERIOD CLK = ~CLK;
		end
	end

	// word slot of a byte address in the memory image
	function automatic int word_index(input addr_t a);
		return int'(a[MEM_AW+1:2]);
	endfunction

	// watchdog, scaled by the number of requests
	initial begin
		wait (loaded);
		repeat (RST_CYCLES + LINE_CYCLES * (ops.size() + 1)) @(posedge CLK);
		$display("Timeout: the cache stopped answering before the last request");
		$display("checks %0d, value errors %0d, other errors %0d",
			checks, value_errors, other_errors + 1);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	// memory port watch, a word completes on the next rising edge
	always @(negedge CLK) begin
		if (nRST && (mem_ren || mem_wen)) begin
			traffic = 1'b1;
			if (!mem_wait) begin
				if (mem_addr >= addr_t'(MEM_WORDS * 4)) begin
					$display("memory access at %h is outside the memory model", mem_addr);
					other_errors++;
				end else if (mem_wen && (mem_store !== exp_mem[word_index(mem_addr)])) begin
					$display("Error mem_store at %h: expected %h, got %h",
						mem_addr, exp_mem[word_index(mem_addr)], mem_store);
					value_errors++;
				end else if (mem_ren && (mem_load !== exp_mem[word_index(mem_addr)])) begin
					// stale memory means a dirty word was not written back
					$display("Error mem_load at %h: expected %h, got %h",
						mem_addr, exp_mem[word_index(mem_addr)], mem_load);
					value_errors++;
				end
			end
		end
	end

	task automatic load_requests();
		int    fd;
		int    n;
		string line;
		string op;
		addr_t a;
		word_t s;
		word_t e;
		int    h;
		fd = $fopen("tb/dcache_testdata.txt", "r");
		if (fd == 0) begin
			$display("cannot open the request file tb/dcache_testdata.txt");
			other_errors++;
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			// skip comment and blank lines
			if ((n > 0) && (line.len() > 1) && (line.getc(0) != "#")) begin
				n = $sscanf(line, "%s %h %h %h %d", op, a, s, e, h);
				if (n == 5) begin
					ops.push_back(op);
					addrs.push_back(a);
					stores.push_back(s);
					expects.push_back(e);
					must_hit.push_back(h);
				end
			end
		end
		$fclose(fd);
	endtask

	task automatic run_request(input int num);
		int    cycles;
		string op;
		op = ops[num];
		@(posedge CLK);
		traffic = 1'b0;
		dmem_ren   <= (op == "R") || (op == "LL");
		dmem_wen   <= (op == "W") || (op == "SC");
		datomic    <= (op == "LL") || (op == "SC");
		dmem_addr  <= addrs[num];
		dmem_store <= stores[num];
		cycles = 0;
		// hold the request until the cache answers
		do begin
			@(negedge CLK);
			cycles++;
		end while (dhit !== 1'b1);
		if ((must_hit[num] != 0) && ((cycles != 1) || traffic)) begin
			$display("request %0d (%s %h) went to memory but should have hit",
				num, op, addrs[num]);
			other_errors++;
		end
		if ((op == "R") || (op == "LL") || (op == "SC")) begin
			checks++;
			if (dmem_load !== expects[num]) begin
				$display("Error dmem_load, request %0d (%s %h): expected %h, got %h",
					num, op, addrs[num], expects[num], dmem_load);
				value_errors++;
			end
		end
		// a plain store, or a store-conditional that should succeed
		if ((op == "W") || ((op == "SC") && (expects[num] == 32'd1))) begin
			exp_mem[word_index(addrs[num])] = stores[num];
		end
		// request taken on this edge
		@(posedge CLK);
		dmem_ren <= 1'b0;
		dmem_wen <= 1'b0;
		datomic  <= 1'b0;
	endtask

	task automatic run_halt();
		@(posedge CLK);
		halt <= 1'b1;
		do begin
			@(negedge CLK);
		end while (flushed !== 1'b1);
		// flushed must stay up
		repeat (4) begin
			@(negedge CLK);
			if (flushed !== 1'b1) begin
				$display("flushed dropped after the flush had finished");
				other_errors++;
			end
		end
		for (int i = 0; i < MEM_WORDS; i++) begin
			checks++;
			if (mem_i.mem[i] !== exp_mem[i]) begin
				$display("Error mem at %h: expected %h, got %h", i * 4, exp_mem[i], mem_i.mem[i]);
				value_errors++;
			end
		end
	endtask

	initial begin
		nRST         = 1'b0;
		halt         = 1'b0;
		dmem_ren     = 1'b0;
		dmem_wen     = 1'b0;
		datomic      = 1'b0;
		dmem_addr    = '0;
		dmem_store   = '0;
		checks       = 0;
		value_errors = 0;
		other_errors = 0;
		traffic      = 1'b0;
		loaded       = 1'b0;
		// initial memory image
		for (int i = 0; i < MEM_WORDS; i++) begin
			exp_mem[i] = addr_t'(i * 4) ^ 32'hA5A50000;
		end
		load_requests();
		if (ops.size() == 0) begin
			$display("no requests were read from the request file");
			other_errors++;
		end
		loaded = 1'b1;
		repeat (RST_CYCLES) @(posedge CLK);
		nRST <= 1'b1;
		@(negedge CLK);
		checks++;
		if ({dhit, flushed, mem_ren, mem_wen} !== 4'b0000) begin
			$display("Error after reset: dhit %h, flushed %h, mem_ren %h, mem_wen %h",
				dhit, flushed, mem_ren, mem_wen);
			value_errors++;
		end
		for (int i = 0; i < ops.size(); i++) begin
			if (ops[i] == "H") begin
				run_halt();
			end else if ((ops[i] == "R") || (ops[i] == "W") || (ops[i] == "LL")
				|| (ops[i] == "SC")) begin
				run_request(i);
			end else begin
				$display("request %0d has an unknown operation %s", i, ops[i]);
				other_errors++;
			end
		end
		$display("checks %0d, value errors %0d, other errors %0d",
			checks, value_errors, other_errors);
		if ((value_errors == 0) && (other_errors == 0)) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== tb/dcache_testdata.txt ====
# op addr store expected_load must_hit, all hex except must_hit (1 = no memory traffic)
# op is R, W, LL, SC or H; expected_load is ignored for W and H, SC returns 1 or 0
R  00000010 00000000 a5a50010 0
R  00000014 00000000 a5a50014 1
W  00000000 11111111 00000000 0
R  00000000 00000000 11111111 1
W  00000004 22222222 00000000 1
W  00000040 33333333 00000000 0
R  00000040 00000000 33333333 1
R  00000080 00000000 a5a50080 0
R  00000000 00000000 11111111 0
R  00000004 00000000 22222222 1
R  00000044 00000000 a5a50044 0
R  00000040 00000000 33333333 1
LL 00000018 00000000 a5a50018 0
SC 00000018 44444444 00000001 1
SC 00000018 55555555 00000000 1
R  00000018 00000000 44444444 1
LL 00000020 00000000 a5a50020 0
W  00000020 66666666 00000000 1
SC 00000020 77777777 00000000 1
R  00000020 00000000 66666666 1
H  00000000 00000000 00000000 0

// ==== files.f ====
rtl/cache_geom_pkg.sv
rtl/cache_ctrl_pkg.sv
rtl/way_if.sv
rtl/cache_way.sv
rtl/cache_ctrl.sv
rtl/dcache_top.sv
tb/mem_model.sv
tb/dcache_tb.sv
